//--- Makefile
# Verilator build for the execution port and its testbench

TOP = ExecPortTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

obj_dir/V$(TOP): sources.f $(shell cat sources.f)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Regression passed" sim.log; then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- bench/ExecPortTb.sv
`timescale 1ns/100ps

module ExecPortTb
    import ExecPkg::*;
();

    localparam int NumOps        = 2000;
    localparam int MaxPending    = 32;
    localparam int ResetCycles   = 16;
    localparam int TimeoutCycles = NumOps * (DivSteps + 4);
    localparam logic [31:0] Seed = 32'h399d6ea7;

    typedef struct packed {
        logic                 isDiv;
        logic [TagWidth-1:0]  tag;
        logic [SqnWidth-1:0]  sqn;
        logic [DataWidth-1:0] result;
        int                   issueCycle;
    } PendEntry;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 issueValid;
    Opcode                issueOp;
    logic [SqnWidth-1:0]  issueSqn;
    logic [TagWidth-1:0]  issueTag;
    logic [DataWidth-1:0] srcA;
    logic [DataWidth-1:0] srcB;
    logic                 flushValid;
    logic [SqnWidth-1:0]  flushSqn;
    logic                 divStall;
    logic                 wbValid;
    logic [TagWidth-1:0]  wbTag;
    logic [DataWidth-1:0] wbResult;

    PendEntry            pending[$];
    logic [31:0]         rngState;
    logic [SqnWidth-1:0] nextSqn;
    int                  cycle;
    int                  issueCount;
    int                  wbCount;
    int                  flushCount;
    int                  timeoutCnt = 0;
    logic                divPending;    // A divide is somewhere between issue and writeback
    int                  divIssueCycle;

    ExecPort i_ExecPort (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueOp(issueOp), .issueSqn(issueSqn),
        .issueTag(issueTag), .srcA(srcA), .srcB(srcB),
        .flushValid(flushValid), .flushSqn(flushSqn),
        .divStall(divStall), .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult)
    );

    always #4 clk = ~clk; // 8 ns period

    // *************************************************************************
    // Helpers and reference model
    // *************************************************************************

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Positive signed distance in the wrapping sequence space
    function automatic logic youngerThan(
        input logic [SqnWidth-1:0] a,
        input logic [SqnWidth-1:0] b
    );
        logic [SqnWidth-1:0] gap;
        gap = a - b;
        return $signed(gap) > 0;
    endfunction

    function automatic logic [DataWidth-1:0] modelResult(
        input Opcode                op,
        input logic [DataWidth-1:0] a,
        input logic [DataWidth-1:0] b
    );
        case (op)
            opAdd:  return a + b;
            opSub:  return a - b;
            opAnd:  return a & b;
            opOr:   return a | b;
            opXor:  return a ^ b;
            opSll:  return a << b[4:0];
            opSrl:  return a >> b[4:0];
            opSlt:  return ($signed(a) < $signed(b)) ? DataWidth'(1) : '0;
            opSltu: return (a < b) ? DataWidth'(1) : '0;
            opDivu: return (b == '0) ? '1 : a / b;
            opRemu: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    function automatic logic tagInUse(input logic [TagWidth-1:0] tag);
        foreach (pending[i]) begin
            if (pending[i].tag == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    // *************************************************************************
    // Stimulus and checking, one clock cycle per call
    // *************************************************************************

    task automatic driveInputs();
        logic [31:0]          r;
        Opcode                op;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        PendEntry             entry;
        r = nextRandom();
        issueValid = 1'b0;
        flushValid = 1'b0;
        if (issueCount < NumOps && r[1:0] != 2'b00 && pending.size() < MaxPending &&
                !tagInUse(issueCount[TagWidth-1:0])) begin
            op = Opcode'(4'(nextRandom() % 11));
            if (isDivOp(op) && divPending) op = Opcode'(4'(nextRandom() % 9));
            a = nextRandom();
            b = nextRandom();
            if (isDivOp(op)) begin
                case (r[4:2])
                    3'd0:    b = '0;
                    3'd1:    b = b >> r[9:5];
                    3'd2:    b = {24'b0, b[7:0]};
                    default: ;
                endcase
                assert (divStall === 1'b0)
                    else failRun("a divide was due to issue while divStall was high");
                divPending    = 1'b1;
                divIssueCycle = cycle;
            end
            issueValid = 1'b1;
            issueOp    = op;
            issueSqn   = nextSqn;
            issueTag   = issueCount[TagWidth-1:0];
            srcA       = a;
            srcB       = b;
            entry = '{isDiv: isDivOp(op), tag: issueCount[TagWidth-1:0], sqn: nextSqn,
                      result: modelResult(op, a, b), issueCycle: cycle};
            pending.push_back(entry);
            nextSqn    = nextSqn + SqnWidth'(1);
            issueCount = issueCount + 1;
        end
        if (issueCount < NumOps && r[20:16] == 5'd0) begin
            flushValid = 1'b1;
            flushSqn   = nextSqn - SqnWidth'(r[14:11]) - SqnWidth'(1);
        end
    endtask

    task automatic checkOutputs();
        logic     expStall;
        int       hits;
        int       idx;
        PendEntry entry;
        expStall = divPending && (cycle > divIssueCycle);
        assert (divStall === expStall)
            else failRun($sformatf("error: divStall is %h, expected %h", divStall, expStall));
        if (wbValid === 1'b1) begin
            hits = 0;
            idx  = -1;
            foreach (pending[i]) begin
                if (pending[i].tag == wbTag) begin
                    hits = hits + 1;
                    idx  = i;
                end
            end
            assert (hits == 1)
                else failRun($sformatf("writeback of tag %h matched %0d pending operations",
                                       wbTag, hits));
            entry = pending[idx];
            assert (wbResult === entry.result)
                else failRun($sformatf("error: wbResult for tag %h is %h, expected %h",
                                       wbTag, wbResult, entry.result));
            if (entry.isDiv) begin
                assert (cycle - entry.issueCycle >= DivSteps + 2)
                    else failRun($sformatf("divide with tag %h finished too early", wbTag));
                divPending = 1'b0;
            end else begin
                assert (cycle - entry.issueCycle == 2)
                    else failRun($sformatf("ALU op with tag %h took %0d cycles instead of 2",
                                           wbTag, cycle - entry.issueCycle));
            end
            pending.delete(idx);
            wbCount = wbCount + 1;
        end
        foreach (pending[i]) begin
            assert (pending[i].isDiv || cycle < pending[i].issueCycle + 2)
                else failRun($sformatf("ALU op with tag %h never wrote back", pending[i].tag));
        end
        // The flush acts at the coming edge, after this cycle's writeback
        if (flushValid) begin
            for (int i = pending.size() - 1; i >= 0; i--) begin
                if (youngerThan(pending[i].sqn, flushSqn)) begin
                    if (pending[i].isDiv) divPending = 1'b0;
                    pending.delete(i);
                    flushCount = flushCount + 1;
                end
            end
        end
    endtask

    task automatic runCycle();
        driveInputs();
        @(negedge clk);
        checkOutputs();
        @(posedge clk);
        #1;
        cycle = cycle + 1;
    endtask

    always @(posedge clk) begin
        timeoutCnt = timeoutCnt + 1;
        if (timeoutCnt > TimeoutCycles + ResetCycles) begin
            failRun($sformatf("run did not finish within %0d cycles", TimeoutCycles));
        end
    end

    initial begin
        rst        = 1'b1;
        issueValid = 1'b0;
        issueOp    = opAdd;
        issueSqn   = '0;
        issueTag   = '0;
        srcA       = '0;
        srcB       = '0;
        flushValid = 1'b0;
        flushSqn   = '0;
        rngState   = Seed;
        nextSqn    = '0;
        cycle      = 0;
        issueCount = 0;
        wbCount    = 0;
        flushCount = 0;
        divPending = 1'b0;
        divIssueCycle = 0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        while (issueCount < NumOps || pending.size() != 0) begin
            runCycle();
        end
        repeat (DivSteps + 4) runCycle(); // Quiet tail catches stray writebacks
        if (pending.size() == 0 && wbCount + flushCount == issueCount) begin
            $display("Regression passed");
            $finish;
        end else begin
            failRun($sformatf("%0d issued but %0d written back and %0d flushed",
                              issueCount, wbCount, flushCount));
        end
    end

endmodule

//--- bench/ExecPort_asserts.sv
`timescale 1ns/100ps

module ExecPortAsserts
    import ExecPkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 flushValid,
    input logic                 divStall,
    input logic                 wbValid,
    input logic [TagWidth-1:0]  wbTag,
    input logic [DataWidth-1:0] wbResult
);

    // Nothing can have completed in the first cycle out of reset
    wbQuietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !wbValid)
        else $error("wbValid was high in the first cycle after reset");

    // Once raised, the stall only drops through a writeback or a flush
    stallHeldToWriteback: assert property (@(posedge clk) disable iff (rst)
        $fell(divStall) |-> $past(wbValid) || $past(flushValid))
        else $error("divStall dropped without a writeback or a flush");

    wbKnown: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> !$isunknown({wbTag, wbResult}))
        else $error("wbTag or wbResult was unknown during a writeback");

endmodule

bind ExecPort ExecPortAsserts i_ExecPortAsserts (
    .clk(clk), .rst(rst), .flushValid(flushValid), .divStall(divStall),
    .wbValid(wbValid), .wbTag(wbTag), .wbResult(wbResult)
);

//--- sources.f
verilog/ExecPkg.sv
verilog/OperandStage.sv
verilog/IntAlu.sv
verilog/Divider.sv
verilog/ExecPort.sv
bench/ExecPort_asserts.sv
bench/ExecPortTb.sv

//--- verilog/Divider.sv
`timescale 1ns/100ps

module Divider
    import ExecPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 opValid,
    input  Opcode                opOp,
    input  logic [SqnWidth-1:0]  opSqn,
    input  logic [TagWidth-1:0]  opTag,
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,

    input  logic                 wbFree,
    input  logic                 flushValid,
    input  logic [SqnWidth-1:0]  flushSqn,

    output logic                 divBusy,
    output logic                 divValid,
    output logic [TagWidth-1:0]  divTag,
    output logic [DataWidth-1:0] divResult
);

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stDone
    } DivState;

    DivState                 state;
    logic [StepCntWidth-1:0] stepCnt;

    logic [DataWidth-1:0]    divisor;
    logic [DataWidth-1:0]    quo;       // Dividend shifts out, quotient shifts in
    logic [DataWidth-1:0]    rem;
    logic                    wantRem;
    logic [SqnWidth-1:0]     sqn;

    logic                    accept;
    logic                    kill;
    logic [DataWidth+1:0]    trial;
    logic [DataWidth-1:0]    quoNext;
    logic [DataWidth-1:0]    remNext;

    assign accept = opValid && isDivOp(opOp) && (state == stIdle) &&
                    !(flushValid && isYounger(opSqn, flushSqn));
    assign kill   = flushValid && isYounger(sqn, flushSqn);

    // *************************************************************************
    // Restoring step
    // *************************************************************************

    // Extra top bit keeps a zero divisor from looking negative, so it yields
    // all ones and the dividend as remainder
    always_comb begin
        trial = {1'b0, rem, quo[DataWidth-1]} - {2'b00, divisor};
        if (!trial[DataWidth+1]) begin
            remNext = trial[DataWidth-1:0];
            quoNext = {quo[DataWidth-2:0], 1'b1};
        end else begin
            remNext = {rem[DataWidth-2:0], quo[DataWidth-1]};
            quoNext = {quo[DataWidth-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            stepCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (accept) begin
                        state   <= stRun;
                        stepCnt <= '0;
                    end
                end
                stRun: begin
                    if (kill) begin
                        state <= stIdle;
                    end else begin
                        stepCnt <= stepCnt + 1'b1;
                        if (stepCnt == LastStep) state <= stDone;
                    end
                end
                stDone: begin
                    if (wbFree || kill) state <= stIdle; // Writeback beats the flush
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            divisor <= opB;
            quo     <= opA;
            rem     <= '0;
            wantRem <= (opOp == opRemu);
            sqn     <= opSqn;
            divTag  <= opTag;
        end else if (state == stRun) begin
            quo <= quoNext;
            rem <= remNext;
        end
    end

    assign divBusy   = (state != stIdle);
    assign divValid  = (state == stDone);
    assign divResult = wantRem ? rem : quo;

endmodule

//--- verilog/ExecPkg.sv
package ExecPkg;

    // *************************************************************************
    // Widths
    // *************************************************************************

    localparam int DataWidth = 32;
    localparam int SqnWidth = 7;
    localparam int TagWidth = 6;

    localparam int DivSteps = DataWidth; // One quotient bit per step
    localparam int StepCntWidth = $clog2(DivSteps);
    localparam logic [StepCntWidth-1:0] LastStep = StepCntWidth'(DivSteps - 1);

    // *************************************************************************
    // Opcodes
    // *************************************************************************

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,
        opSrl,
        opSlt,
        opSltu,
        opDivu,
        opRemu
    } Opcode;

    function automatic logic isDivOp(input Opcode op);
        return (op == opDivu) || (op == opRemu);
    endfunction

    // True when a is strictly younger than b, modulo the sequence space
    function automatic logic isYounger(
        input logic [SqnWidth-1:0] a,
        input logic [SqnWidth-1:0] b
    );
        logic [SqnWidth-1:0] diff;
        diff = a - b;
        return (diff != '0) && !diff[SqnWidth-1]; // Positive signed difference
    endfunction

endpackage

//--- verilog/ExecPort.sv
`timescale 1ns/100ps

module ExecPort
    import ExecPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 issueValid,
    input  Opcode                issueOp,
    input  logic [SqnWidth-1:0]  issueSqn,
    input  logic [TagWidth-1:0]  issueTag,
    input  logic [DataWidth-1:0] srcA,
    input  logic [DataWidth-1:0] srcB,

    input  logic                 flushValid,
    input  logic [SqnWidth-1:0]  flushSqn,

    output logic                 divStall,
    output logic                 wbValid,
    output logic [TagWidth-1:0]  wbTag,
    output logic [DataWidth-1:0] wbResult
);

    logic                 opValid;
    Opcode                opOp;
    logic [SqnWidth-1:0]  opSqn;
    logic [TagWidth-1:0]  opTag;
    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;

    logic                 aluValid;
    logic [TagWidth-1:0]  aluTag;
    logic [DataWidth-1:0] aluResult;

    logic                 divBusy;
    logic                 divValid;
    logic [TagWidth-1:0]  divTag;
    logic [DataWidth-1:0] divResult;

    OperandStage i_OperandStage (
        .clk(clk), .rst(rst),
        .issueValid(issueValid), .issueOp(issueOp), .issueSqn(issueSqn),
        .issueTag(issueTag), .srcA(srcA), .srcB(srcB),
        .flushValid(flushValid), .flushSqn(flushSqn),
        .opValid(opValid), .opOp(opOp), .opSqn(opSqn),
        .opTag(opTag), .opA(opA), .opB(opB)
    );

    IntAlu i_IntAlu (
        .clk(clk), .rst(rst),
        .opValid(opValid), .opOp(opOp), .opSqn(opSqn),
        .opTag(opTag), .opA(opA), .opB(opB),
        .flushValid(flushValid), .flushSqn(flushSqn),
        .aluValid(aluValid), .aluTag(aluTag), .aluResult(aluResult)
    );

    Divider i_Divider (
        .clk(clk), .rst(rst),
        .opValid(opValid), .opOp(opOp), .opSqn(opSqn),
        .opTag(opTag), .opA(opA), .opB(opB),
        .wbFree(!aluValid), // ALU owns the slot whenever it has a result
        .flushValid(flushValid), .flushSqn(flushSqn),
        .divBusy(divBusy), .divValid(divValid), .divTag(divTag), .divResult(divResult)
    );

    // *************************************************************************
    // Shared writeback slot and divide hold-off
    // *************************************************************************

    assign wbValid  = aluValid || divValid;
    assign wbTag    = aluValid ? aluTag : divTag;
    assign wbResult = aluValid ? aluResult : divResult;

    assign divStall = divBusy || (opValid && isDivOp(opOp)); // Covers the stage gap

endmodule

//--- verilog/IntAlu.sv
`timescale 1ns/100ps

module IntAlu
    import ExecPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 opValid,
    input  Opcode                opOp,
    input  logic [SqnWidth-1:0]  opSqn,
    input  logic [TagWidth-1:0]  opTag,
    input  logic [DataWidth-1:0] opA,
    input  logic [DataWidth-1:0] opB,

    input  logic                 flushValid,
    input  logic [SqnWidth-1:0]  flushSqn,

    output logic                 aluValid,
    output logic [TagWidth-1:0]  aluTag,
    output logic [DataWidth-1:0] aluResult
);

    logic                 accept;
    logic                 kill;
    logic [DataWidth-1:0] result;
    logic [4:0]           shamt;

    assign shamt  = opB[4:0];
    assign kill   = flushValid && isYounger(opSqn, flushSqn);
    assign accept = opValid && !isDivOp(opOp) && !kill;

    always_comb begin
        case (opOp)
            opAdd:   result = opA + opB;
            opSub:   result = opA - opB;
            opAnd:   result = opA & opB;
            opOr:    result = opA | opB;
            opXor:   result = opA ^ opB;
            opSll:   result = opA << shamt;
            opSrl:   result = opA >> shamt;
            opSlt:   result = DataWidth'($signed(opA) < $signed(opB));
            opSltu:  result = DataWidth'(opA < opB);
            default: result = '0; // Divides belong to the divider
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aluValid <= 1'b0;
        end else begin
            aluValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            aluTag    <= opTag;
            aluResult <= result;
        end
    end

endmodule

//--- verilog/OperandStage.sv
`timescale 1ns/100ps

module OperandStage
    import ExecPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 issueValid,
    input  Opcode                issueOp,
    input  logic [SqnWidth-1:0]  issueSqn,
    input  logic [TagWidth-1:0]  issueTag,
    input  logic [DataWidth-1:0] srcA,
    input  logic [DataWidth-1:0] srcB,

    input  logic                 flushValid,
    input  logic [SqnWidth-1:0]  flushSqn,

    output logic                 opValid,
    output Opcode                opOp,
    output logic [SqnWidth-1:0]  opSqn,
    output logic [TagWidth-1:0]  opTag,
    output logic [DataWidth-1:0] opA,
    output logic [DataWidth-1:0] opB
);

    logic issueKill;

    // An op issued under a flush that it is younger than never enters.
    // A held op always leaves at the edge, so the units drop it there
    assign issueKill = flushValid && isYounger(issueSqn, flushSqn);

    always_ff @(posedge clk) begin
        if (rst) begin
            opValid <= 1'b0;
        end else begin
            opValid <= issueValid && !issueKill;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            opOp  <= issueOp;
            opSqn <= issueSqn;
            opTag <= issueTag;
            opA   <= srcA;
            opB   <= srcB;
        end
    end

endmodule
